/* icache_pkg.sv */
package icache_pkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// bus words
	// ~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] word_t; // instruction or data word
	typedef logic [29:0] waddr_t; // word address, byte bits dropped

	// ~~~~~~~~~~~~~~~~~~~~
	// controller state
	// ~~~~~~~~~~~~~~~~~~~~

	// one-hot, one flop per state
	typedef enum logic [2:0] {
		idle    = 3'b001, // waiting for an access
		compare = 3'b010, // tag and data read back, check hit
		fill    = 3'b100  // line refill from memory in progress
	} ctrl_state_t;

endpackage

/* block_ram.sv */
module block_ram #(
	parameter int data_bits = 32,
	parameter int nr_entries = 256,
	localparam int addr_bits = $clog2(nr_entries)
) (
	input  logic                 clk,
	input  logic [addr_bits-1:0] read_addr,
	output logic [data_bits-1:0] read_data,
	input  logic                 wr_en,
	input  logic [addr_bits-1:0] write_addr,
	input  logic [data_bits-1:0] write_data
);

	logic [data_bits-1:0] mem [nr_entries];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[write_addr] <= write_data;
		end
	end

	// registered read, old contents on a same-address write
	always_ff @(posedge clk) begin
		read_data <= mem[read_addr];
	end

endmodule

/* tag_store.sv */
module tag_store import icache_pkg::*; #(
	parameter int cache_size = 8192,
	parameter int line_size = 32,
	localparam int index_bits = $clog2(cache_size / line_size)
) (
	input  logic                  clk,
	input  logic                  rst,
	input  waddr_t                lookup_addr,
	input  waddr_t                latched_addr,
	input  logic                  tag_wr,
	input  logic                  inval,
	input  logic [index_bits-1:0] inval_index,
	output logic                  hit
);

	localparam int nr_lines = cache_size / line_size;
	localparam int offs_bits = $clog2(line_size / 4);
	localparam int tag_bits = 30 - index_bits - offs_bits;
	localparam int tag_idx = offs_bits + index_bits;

	// ~~~~~~~~~~~~~~~~~~~~
	// address fields
	// ~~~~~~~~~~~~~~~~~~~~

	logic [index_bits-1:0] lookup_index;
	logic [index_bits-1:0] latched_index;
	logic [tag_bits-1:0]   latched_tag;
	logic [tag_bits-1:0]   stored_tag; // tag read at lookup_index

	assign lookup_index  = lookup_addr[offs_bits +: index_bits];
	assign latched_index = latched_addr[offs_bits +: index_bits];
	assign latched_tag   = latched_addr[tag_idx +: tag_bits];

	block_ram #(
		.data_bits(tag_bits),
		.nr_entries(nr_lines)
	) tag_ram (
		.clk(clk),
		.read_addr(lookup_index),
		.read_data(stored_tag),
		.wr_en(tag_wr),
		.write_addr(latched_index),
		.write_data(latched_tag)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// valid bits
	// ~~~~~~~~~~~~~~~~~~~~

	logic [nr_lines-1:0] valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else begin
			if (inval) begin
				valid[inval_index] <= 1'b0;
			end
			if (tag_wr) begin
				valid[latched_index] <= 1'b1; // completed fill wins
			end
		end
	end

	assign hit = valid[latched_index] && (stored_tag == latched_tag);

endmodule

/* line_store.sv */
module line_store import icache_pkg::*; #(
	parameter int cache_size = 8192,
	parameter int line_size = 32,
	localparam int offs_bits = $clog2(line_size / 4)
) (
	input  logic                 clk,
	input  waddr_t               lookup_addr,
	input  waddr_t               latched_addr,
	input  logic                 fill_word,
	input  logic [offs_bits-1:0] fill_offs,
	input  word_t                fill_data,
	output word_t                data
);

	localparam int nr_words = cache_size / 4;
	localparam int index_bits = $clog2(cache_size / line_size);
	localparam int ram_bits = index_bits + offs_bits;

	logic [ram_bits-1:0]   read_addr;  // {index, offset} of the lookup
	logic [index_bits-1:0] fill_index;
	logic [ram_bits-1:0]   write_addr;

	assign read_addr  = lookup_addr[ram_bits-1:0];
	assign fill_index = latched_addr[offs_bits +: index_bits];
	assign write_addr = {fill_index, fill_offs}; // word slot inside the line

	block_ram #(
		.data_bits(32),
		.nr_entries(nr_words)
	) data_ram (
		.clk(clk),
		.read_addr(read_addr),
		.read_data(data),
		.wr_en(fill_word),
		.write_addr(write_addr),
		.write_data(fill_data)
	);

endmodule

/* fill_engine.sv */
module fill_engine import icache_pkg::*; #(
	parameter int line_size = 32,
	localparam int offs_bits = $clog2(line_size / 4)
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 fill_start,
	input  waddr_t               latched_addr,
	output logic                 mem_access,
	output waddr_t               mem_addr,
	input  logic                 mem_ack,
	input  logic                 mem_error,
	output logic                 fill_word,
	output logic [offs_bits-1:0] fill_offs,
	output logic                 line_done,
	output logic                 fill_error
);

	localparam logic [offs_bits-1:0] last_offs = {offs_bits{1'b1}};

	// ~~~~~~~~~~~~~~~~~~~~
	// word counter
	// ~~~~~~~~~~~~~~~~~~~~

	logic                 active;   // fill running
	logic [offs_bits-1:0] offs;     // word being fetched
	logic [offs_bits-1:0] next_offs;
	logic [offs_bits-1:0] mem_offs;

	assign next_offs = offs + 1'b1;

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			offs   <= '0;
		end else if (fill_start) begin
			active <= 1'b1;
			offs   <= '0; // lines always fill from word 0
		end else if (active) begin
			if (fill_error || line_done) begin
				active <= 1'b0;
			end
			if (fill_word) begin
				offs <= next_offs;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// memory port
	// ~~~~~~~~~~~~~~~~~~~~

	// address moves on with the ack, request drops for the ack cycle
	assign mem_offs   = mem_ack ? next_offs : offs;
	assign mem_addr   = {latched_addr[29:offs_bits], mem_offs};
	assign mem_access = active && !mem_ack;

	// an error in the same cycle as an ack discards the word
	assign fill_word  = active && mem_ack && !mem_error;
	assign fill_offs  = offs;
	assign line_done  = fill_word && (offs == last_offs);
	assign fill_error = active && mem_error;

endmodule

/* cache_ctrl.sv */
module cache_ctrl import icache_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   access,
	input  waddr_t addr,
	input  logic   inval,
	input  logic   hit,
	input  logic   line_done,
	input  logic   fill_error,
	output waddr_t lookup_addr,
	output waddr_t latched_addr,
	output logic   fill_start,
	output logic   ack,
	output logic   error
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	logic accept;      // access taken into compare
	logic line_done_q; // tag and last word readable one cycle after the write

	// no new lookup in the error ack cycle, the cpu still holds the old address
	assign accept = (state == idle) && access && !error && !inval;

	// ~~~~~~~~~~~~~~~~~~~~
	// state machine
	// ~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		next_state = state;
		unique case (state)
			idle: begin
				if (accept) begin
					next_state = compare;
				end
			end
			compare: begin
				next_state = hit ? idle : fill;
			end
			fill: begin
				if (fill_error) begin
					next_state = idle;
				end else if (line_done_q) begin
					next_state = compare; // look up again, now hits
				end
			end
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= idle;
			line_done_q <= 1'b0;
			error       <= 1'b0;
		end else begin
			state       <= next_state;
			line_done_q <= line_done;
			error       <= (state == fill) && fill_error;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// address and outputs
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (accept) begin
			latched_addr <= addr;
		end
	end

	assign lookup_addr = (state == idle) ? addr : latched_addr;
	assign fill_start  = (state == compare) && !hit;
	assign ack         = ((state == compare) && hit) || error;

endmodule

/* icache_top.sv */
module icache_top import icache_pkg::*; #(
	parameter int cache_size = 8192,
	parameter int line_size = 32,
	localparam int index_bits = $clog2(cache_size / line_size)
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  access,
	input  waddr_t                addr,
	output word_t                 data,
	output logic                  ack,
	output logic                  error,
	input  logic                  inval,
	input  logic [index_bits-1:0] inval_index,
	output logic                  mem_access,
	output waddr_t                mem_addr,
	input  word_t                 mem_data,
	input  logic                  mem_ack,
	input  logic                  mem_error
);

	localparam int offs_bits = $clog2(line_size / 4);

	waddr_t                lookup_addr;
	waddr_t                latched_addr;
	logic                  fill_start;
	logic                  hit;
	logic                  fill_word;
	logic [offs_bits-1:0]  fill_offs;
	logic                  line_done;
	logic                  fill_error;
	logic                  clr_line;
	logic [index_bits-1:0] clr_index;

	// a refill drops the old line before any of its words are overwritten
	assign clr_line  = inval || fill_start;
	assign clr_index = fill_start ? latched_addr[offs_bits +: index_bits] : inval_index;

	cache_ctrl ctrl_i (
		.clk(clk),
		.rst(rst),
		.access(access),
		.addr(addr),
		.inval(inval),
		.hit(hit),
		.line_done(line_done),
		.fill_error(fill_error),
		.lookup_addr(lookup_addr),
		.latched_addr(latched_addr),
		.fill_start(fill_start),
		.ack(ack),
		.error(error)
	);

	tag_store #(.cache_size(cache_size), .line_size(line_size)) tags_i (
		.clk(clk),
		.rst(rst),
		.lookup_addr(lookup_addr),
		.latched_addr(latched_addr),
		.tag_wr(line_done),
		.inval(clr_line),
		.inval_index(clr_index),
		.hit(hit)
	);

	line_store #(.cache_size(cache_size), .line_size(line_size)) lines_i (
		.clk(clk),
		.lookup_addr(lookup_addr),
		.latched_addr(latched_addr),
		.fill_word(fill_word),
		.fill_offs(fill_offs),
		.fill_data(mem_data),
		.data(data)
	);

	fill_engine #(.line_size(line_size)) fill_i (
		.clk(clk),
		.rst(rst),
		.fill_start(fill_start),
		.latched_addr(latched_addr),
		.mem_access(mem_access),
		.mem_addr(mem_addr),
		.mem_ack(mem_ack),
		.mem_error(mem_error),
		.fill_word(fill_word),
		.fill_offs(fill_offs),
		.line_done(line_done),
		.fill_error(fill_error)
	);

endmodule

/* tb_clock.sv */
module tb_clock #(
	parameter int period = 40,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	initial begin
		rst <= 1'b1;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0; // released on an edge like any other input
	end

endmodule

/* tb_memory.sv */
module tb_memory import icache_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   mem_access,
	input  waddr_t mem_addr,
	output word_t  mem_data,
	output logic   mem_ack,
	output logic   mem_error,
	output waddr_t served_addr, // word answered by the current pulse
	input  logic   err_en,
	input  waddr_t err_addr
);

	timeunit 1ns;
	timeprecision 1ps;

	int     seed = 32'h9e03;
	int     wait_left;
	logic   req_seen;
	waddr_t req_addr;

	// contents are a fixed function of the word address
	function automatic word_t mem_word(input waddr_t a);
		return (32'(a) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// request sampling
	// ~~~~~~~~~~~~~~~~~~~~

	initial begin
		req_seen <= 1'b0;
		req_addr <= '0;
		forever begin
			@(negedge clk);
			req_seen <= mem_access && !rst;
			req_addr <= mem_addr;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// response
	// ~~~~~~~~~~~~~~~~~~~~

	initial begin
		mem_data    <= '0;
		mem_ack     <= 1'b0;
		mem_error   <= 1'b0;
		served_addr <= '0;
		wait_left   <= 0;
		forever begin
			@(posedge clk);
			mem_ack   <= 1'b0;
			mem_error <= 1'b0;
			if (rst) begin
				wait_left <= 0;
			end else if (req_seen && !mem_ack && !mem_error) begin
				if (wait_left == 0) begin
					served_addr <= req_addr;
					if (err_en && req_addr == err_addr) begin
						mem_error <= 1'b1; // ends the fill, no word
					end else begin
						mem_ack  <= 1'b1;
						mem_data <= mem_word(req_addr);
					end
					wait_left <= $random(seed) & 3; // 0 to 3 idle cycles next time
				end else begin
					wait_left <= wait_left - 1;
				end
			end
		end
	end

endmodule

/* tb_icache.sv */
module tb_icache import icache_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int cache_size = 8192;
	localparam int line_size  = 32;
	localparam int nr_lines   = cache_size / line_size;
	localparam int words      = line_size / 4;
	localparam int index_bits = $clog2(nr_lines);
	localparam int offs_bits  = $clog2(words);
	localparam int tag_bits   = 30 - index_bits - offs_bits;
	localparam int timeout    = 200; // cycles for any single wait
	localparam int nr_ops     = 400;

	logic                  clk;
	logic                  rst;
	logic                  access;
	waddr_t                addr;
	word_t                 data;
	logic                  ack;
	logic                  error;
	logic                  inval;
	logic [index_bits-1:0] inval_index;
	logic                  mem_access;
	waddr_t                mem_addr;
	word_t                 mem_data;
	logic                  mem_ack;
	logic                  mem_error;
	waddr_t                served_addr;
	logic                  err_en;
	waddr_t                err_addr;

	int seed = 32'h9e03;
	int hits = 0;
	int misses = 0;
	int errors_seen = 0;

	logic                shadow_valid [nr_lines]; // reference valid bits
	logic [tag_bits-1:0] shadow_tag [nr_lines];

	tb_clock #(.period(40), .reset_cycles(4)) clock_i (.clk(clk), .rst(rst));

	tb_memory memory_i (
		.clk(clk),
		.rst(rst),
		.mem_access(mem_access),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_ack(mem_ack),
		.mem_error(mem_error),
		.served_addr(served_addr),
		.err_en(err_en),
		.err_addr(err_addr)
	);

	icache_top #(.cache_size(cache_size), .line_size(line_size)) icache_top_i (
		.clk(clk),
		.rst(rst),
		.access(access),
		.addr(addr),
		.data(data),
		.ack(ack),
		.error(error),
		.inval(inval),
		.inval_index(inval_index),
		.mem_access(mem_access),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.mem_ack(mem_ack),
		.mem_error(mem_error)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic stop_run();
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input waddr_t got, input waddr_t exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
			stop_run();
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// model and stimulus
	// ~~~~~~~~~~~~~~~~~~~~

	function automatic word_t mem_word(input waddr_t a);
		return (32'(a) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
	endfunction

	// four tags over eight indexes, so conflicts and reuse both happen
	function automatic waddr_t pick_addr();
		logic [tag_bits-1:0]   tag;
		logic [index_bits-1:0] index;
		logic [offs_bits-1:0]  offs;

		tag   = tag_bits'($random(seed) & 3);
		index = index_bits'($random(seed) & 7);
		offs  = offs_bits'($random(seed));
		return {tag, index, offs};
	endfunction

	task automatic pulse_inval(input logic [index_bits-1:0] index);
		@(posedge clk);
		access      <= 1'b0;
		inval       <= 1'b1;
		inval_index <= index;
		@(posedge clk);
		inval <= 1'b0;
		shadow_valid[index] = 1'b0;
	endtask

	task automatic read_word(input waddr_t a, input logic inject, output logic was_miss);
		logic [index_bits-1:0] index;
		logic [tag_bits-1:0]   tag;
		logic                  exp_hit;
		logic                  exp_err;
		waddr_t                base;
		int                    cycles;
		int                    req_cycles;
		int                    acks;

		index      = a[offs_bits +: index_bits];
		tag        = a[29 -: tag_bits];
		base       = {a[29:offs_bits], {offs_bits{1'b0}}};
		exp_hit    = shadow_valid[index] && (shadow_tag[index] == tag);
		exp_err    = inject && !exp_hit; // a hit never reaches memory
		cycles     = 0;
		req_cycles = 0;
		acks       = 0;
		@(posedge clk);
		access   <= 1'b1;
		addr     <= a;
		err_en   <= inject;
		err_addr <= base + waddr_t'($random(seed) & (words - 1));
		do begin
			@(negedge clk);
			cycles++;
			if (mem_access) req_cycles++;
			if (mem_ack) begin
				check_addr("memory word address", served_addr, base + waddr_t'(acks));
				acks++;
			end
			if (cycles > timeout) begin
				$display("the cache gave no ack within %0d cycles for address %h", timeout, a);
				stop_run();
			end
		end while (!ack);

		check_flag("error", error, exp_err);
		if (exp_err) begin
			shadow_valid[index] = 1'b0; // failed fill leaves the line invalid
			errors_seen++;
		end else begin
			check_word("data", data, mem_word(a));
			if (exp_hit) begin
				check_count("cycles to ack", cycles, 2);
				check_count("mem_access cycles", req_cycles, 0);
				hits++;
			end else begin
				check_count("mem_ack pulses", acks, words);
				misses++;
			end
			shadow_valid[index] = 1'b1;
			shadow_tag[index]   = tag;
		end
		was_miss = !exp_hit && !exp_err;
	endtask

	initial begin
		int     cycles;
		int     roll;
		waddr_t a;
		logic   was_miss;

		access      <= 1'b0;
		addr        <= '0;
		inval       <= 1'b0;
		inval_index <= '0;
		err_en      <= 1'b0;
		err_addr    <= '0;
		for (int i = 0; i < nr_lines; i++) begin
			shadow_valid[i] = 1'b0; // reset clears every line
			shadow_tag[i]   = '0;
		end

		cycles = 0;
		while (rst !== 1'b0) begin
			@(negedge clk);
			cycles++;
			if (cycles > timeout) begin
				$display("reset was never released");
				stop_run();
			end
		end

		// outputs quiet after reset
		check_flag("ack", ack, 1'b0);
		check_flag("error", error, 1'b0);
		check_flag("mem_access", mem_access, 1'b0);

		for (int n = 0; n < nr_ops; n++) begin
			roll = $random(seed) & 15;
			if (roll == 0) begin
				pulse_inval(index_bits'($random(seed) & 7));
			end else begin
				a = pick_addr();
				read_word(a, roll == 1, was_miss);
				if (was_miss) begin
					// another word of the line just filled, expected to hit
					a = {a[29:offs_bits], offs_bits'($random(seed))};
					read_word(a, 1'b0, was_miss);
				end
			end
		end

		if (hits == 0 || misses == 0 || errors_seen == 0) begin
			$display("the random reads did not cover hits, misses and memory errors");
			stop_run();
		end else begin
			$display("%0d hits, %0d misses, %0d memory errors", hits, misses, errors_seen);
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

/* build.f */
icache_pkg.sv
block_ram.sv
tag_store.sv
line_store.sv
fill_engine.sv
cache_ctrl.sv
icache_top.sv
tb_clock.sv
tb_memory.sv
tb_icache.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_icache -f build.f
./obj_dir/Vtb_icache
